// ==== verilog/stackPkg.sv ====
package stackPkg;

  // Command set shared by the data and return stacks
  typedef enum logic [2:0] {
    OP_NONE          = 3'd0,
    OP_PUSH          = 3'd1,
    OP_POP           = 3'd2,  // Drops data+1 entries
    OP_REPLACE       = 3'd3,  // Overwrites top of stack
    OP_INDEX_RESET   = 3'd4,
    OP_INDEX_PUSH    = 3'd5,  // Index reset, then push at offset
    OP_UNDERFLOW_GET = 3'd6,
    OP_UNDERFLOW_SET = 3'd7
  } stackOp_t;

  // Result of the last command, or level of the stack
  typedef enum logic [2:0] {
    ST_NONE       = 3'd0,
    ST_EMPTY      = 3'd1,  // Index sits on the underflow limit
    ST_FULL       = 3'd2,
    ST_UNDERFLOW  = 3'd3,
    ST_OVERFLOW   = 3'd4,
    ST_BAD_OFFSET = 3'd5
  } stackStatus_t;

  // Control part of a command; data and limits are sized per instance
  typedef struct packed {
    stackOp_t op;
    logic     dropTos;  // Underflow set only
  } stackCtrl_t;

  // Owner of a RAM port, doubles as the RAM region bit
  typedef enum logic {
    PORT_DATA   = 1'b0,  // Lower half of the RAM
    PORT_RETURN = 1'b1   // Upper half
  } memPort_t;

endpackage

// ==== verilog/stackRam.sv ====
`timescale 1ns/1ps

// Shared storage for both stacks
// Region bit is the MSB of addr
module stackRam #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             we,
  input  logic [DEPTH:0]   addr,
  input  logic [WIDTH-1:0] wdata,
  output logic [WIDTH-1:0] rdata
);

  localparam int WORDS = 2 ** (DEPTH + 1);  // Two stacks of 2^DEPTH frames

  logic [WIDTH-1:0] mem [WORDS];

  // Single port, read data one cycle after the access
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end else begin
      rdata <= mem[addr];  // Holds last read during writes
    end
  end

endmodule

// ==== verilog/memArbiter.sv ====
`timescale 1ns/1ps

// Round-robin access to the stack RAM for the two stack units
module memArbiter #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [1:0]       req,
  input  logic [1:0]       we,
  input  logic [DEPTH-1:0] addr0,
  input  logic [DEPTH-1:0] addr1,
  input  logic [WIDTH-1:0] wdata0,
  input  logic [WIDTH-1:0] wdata1,
  output logic [1:0]       gnt,
  output logic             ramWe,
  output logic [DEPTH:0]   ramAddr,
  output logic [WIDTH-1:0] ramWdata
);
  import stackPkg::*;

  memPort_t         lastGnt;  // Owner of the most recent grant
  memPort_t         owner;    // Winner in this cycle
  logic [DEPTH-1:0] selAddr;

  // Data wins if alone, or on a tie when return went last
  always_comb begin
    owner = PORT_RETURN;
    if (req[PORT_DATA] && (!req[PORT_RETURN] || lastGnt == PORT_RETURN)) begin
      owner = PORT_DATA;
    end
  end

  always_comb begin
    gnt = 2'b00;
    if (|req) begin
      gnt[owner] = 1'b1;
    end
  end

  // Winner's fields onto the RAM
  assign selAddr  = (owner == PORT_DATA) ? addr0 : addr1;
  assign ramAddr  = {owner, selAddr};  // Region bit on top
  assign ramWdata = (owner == PORT_DATA) ? wdata0 : wdata1;
  assign ramWe    = (|req) && we[owner];  // Idle cycles read, never write

  always_ff @(posedge clk) begin
    if (reset) begin
      lastGnt <= PORT_RETURN;  // Data takes the first tie
    end else if (|req) begin
      lastGnt <= owner;
    end
  end

  gntValid: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(gnt) && ((gnt & ~req) == 2'b00)
  ) else $error("memArbiter: bad grant %b for request %b", gnt, req);

endmodule

// ==== verilog/stackUnit.sv ====
`timescale 1ns/1ps

// One stack controller with a cached top three entries
module stackUnit #(
  parameter int                 WIDTH = 8,
  parameter int                 DEPTH = 4,
  parameter stackPkg::memPort_t BASE  = stackPkg::PORT_DATA
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  stackPkg::stackCtrl_t   ctrl,
  input  logic [WIDTH-1:0]       data,
  input  logic [DEPTH:0]         offset,
  input  logic [DEPTH:0]         underflowLimit,
  input  logic [DEPTH:0]         upperLimit,
  input  logic [DEPTH:0]         lowerLimit,
  output logic                   busy,
  output logic                   done,
  output logic [DEPTH:0]         index,
  output logic [WIDTH-1:0]       out,
  output logic [WIDTH-1:0]       out1,
  output logic [WIDTH-1:0]       out2,
  output stackPkg::stackStatus_t status,
  output logic                   memReq,
  output logic                   memWe,
  output logic [DEPTH-1:0]       memAddr,
  output logic [WIDTH-1:0]       memWdata,
  input  logic                   memGnt,
  input  logic [WIDTH-1:0]       memRdata
);
  import stackPkg::*;

  localparam logic [DEPTH:0] FULL = 1 << DEPTH;
  localparam int CW = ((WIDTH > DEPTH) ? WIDTH : DEPTH + 1) + 1;  // Pop check width

  typedef enum logic [2:0] {
    S_IDLE,
    S_WRITE,
    S_READ_REQ,
    S_READ_CAP,
    S_FINISH
  } state_t;

  state_t           state;
  logic [DEPTH-1:0] wrAddr;
  logic [WIDTH-1:0] wrData;
  logic [DEPTH-1:0] getAddr;
  logic             refresh;  // Top three reload, else single get
  logic [1:0]       slot;     // 0 -> out, 1 -> out1, 2 -> out2

  // Decode of the command at start
  logic [DEPTH:0]   nextIndex;
  stackStatus_t     nextStatus;
  logic             ruleStatus;
  logic             needWrite;
  logic             needRefresh;
  logic             needGet;
  logic [DEPTH-1:0] nextWrAddr;
  logic [DEPTH:0]   topPos;
  logic [DEPTH:0]   windowPos;
  logic             windowBad;
  logic             popUnder;
  logic [DEPTH:0]   rdPos;
  logic             slotValid;

  function automatic stackStatus_t statusOf(input logic [DEPTH:0] idx,
                                            input logic [DEPTH:0] limit);
    if (idx == FULL) return ST_FULL;
    else if (idx == limit) return ST_EMPTY;
    else if (idx < limit) return ST_UNDERFLOW;
    else return ST_NONE;
  endfunction

  assign topPos    = index - 1'b1;
  assign windowPos = lowerLimit + offset;
  assign windowBad = (upperLimit - lowerLimit) <= offset;
  // index - data <= limit, without wrapping
  assign popUnder  = (CW'(data) + CW'(underflowLimit)) >= CW'(index);

  always_comb begin
    nextIndex   = index;
    nextStatus  = status;
    ruleStatus  = 1'b0;
    needWrite   = 1'b0;
    needRefresh = 1'b0;
    needGet     = 1'b0;
    nextWrAddr  = index[DEPTH-1:0];
    case (ctrl.op)
      OP_NONE: ruleStatus = 1'b1;  // Picks up a changed underflow limit
      OP_PUSH: begin
        if (index == FULL) begin
          nextStatus = ST_OVERFLOW;
        end else begin
          needWrite   = 1'b1;
          needRefresh = 1'b1;
          nextIndex   = index + 1'b1;
          ruleStatus  = 1'b1;
        end
      end
      OP_POP: begin
        if (popUnder) begin
          nextStatus = ST_UNDERFLOW;
        end else begin
          needRefresh = 1'b1;
          nextIndex   = index - (DEPTH + 1)'(data) - 1'b1;
          ruleStatus  = 1'b1;
        end
      end
      OP_REPLACE: begin
        if (index <= underflowLimit) begin
          nextStatus = ST_UNDERFLOW;
        end else begin
          needWrite   = 1'b1;
          needRefresh = 1'b1;
          nextWrAddr  = topPos[DEPTH-1:0];
          ruleStatus  = 1'b1;
        end
      end
      OP_INDEX_RESET: begin
        if (offset > index) begin
          nextStatus = ST_BAD_OFFSET;
        end else begin
          nextIndex  = offset;
          ruleStatus = 1'b1;
        end
      end
      OP_INDEX_PUSH: begin
        if (offset > index) begin
          nextStatus = ST_BAD_OFFSET;
        end else if (offset == FULL) begin
          nextStatus = ST_OVERFLOW;
        end else begin
          needWrite   = 1'b1;
          needRefresh = 1'b1;
          nextWrAddr  = offset[DEPTH-1:0];
          nextIndex   = offset + 1'b1;
          ruleStatus  = 1'b1;
        end
      end
      OP_UNDERFLOW_GET: begin
        if (windowBad) begin
          nextStatus = ST_BAD_OFFSET;
        end else begin
          needGet    = 1'b1;
          nextStatus = ST_NONE;
        end
      end
      OP_UNDERFLOW_SET: begin
        if (windowBad) begin
          nextStatus = ST_BAD_OFFSET;
        // Dropping from an empty stack would wrap the index
        end else if (ctrl.dropTos && (index == underflowLimit || index == '0)) begin
          nextStatus = ST_UNDERFLOW;
        end else begin
          needWrite  = 1'b1;
          nextWrAddr = windowPos[DEPTH-1:0];
          ruleStatus = 1'b1;
          if (ctrl.dropTos) nextIndex = topPos;
        end
      end
      default: nextStatus = status;
    endcase
    if (ruleStatus) nextStatus = statusOf(nextIndex, underflowLimit);
  end

  // Refresh position for the current slot, below 0 reads as zero
  assign rdPos     = index - 1'b1 - (DEPTH + 1)'(slot);
  assign slotValid = !refresh || (index > (DEPTH + 1)'(slot));

  assign busy     = (state != S_IDLE);
  assign done     = (state == S_FINISH);
  assign memReq   = (state == S_WRITE) || (state == S_READ_REQ && slotValid);
  assign memWe    = (state == S_WRITE);
  assign memWdata = wrData;
  assign memAddr  = (state == S_WRITE) ? wrAddr : (refresh ? rdPos[DEPTH-1:0] : getAddr);

  always_ff @(posedge clk) begin
    if (start && state == S_IDLE) begin
      wrAddr  <= nextWrAddr;
      wrData  <= data;
      getAddr <= windowPos[DEPTH-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= S_IDLE;
      index   <= '0;
      status  <= ST_EMPTY;
      out     <= '0;
      out1    <= '0;
      out2    <= '0;
      refresh <= 1'b0;
      slot    <= 2'd0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            index   <= nextIndex;  // Refresh reads use the new index
            status  <= nextStatus;
            refresh <= needRefresh;
            slot    <= 2'd0;
            if (needWrite) state <= S_WRITE;
            else if (needRefresh || needGet) state <= S_READ_REQ;
            else state <= S_FINISH;  // Failed checks end here too
          end
        end
        S_WRITE: begin
          if (memGnt) state <= refresh ? S_READ_REQ : S_FINISH;
        end
        S_READ_REQ: begin
          if (!slotValid) begin
            // This slot and all deeper ones are below the stack bottom
            out2 <= '0;
            if (slot <= 2'd1) out1 <= '0;
            if (slot == 2'd0) out <= '0;
            state <= S_FINISH;
          end else if (memGnt) begin
            state <= S_READ_CAP;
          end
        end
        S_READ_CAP: begin
          case (slot)
            2'd0:    out  <= memRdata;
            2'd1:    out1 <= memRdata;
            default: out2 <= memRdata;
          endcase
          if (refresh && slot != 2'd2) begin
            slot  <= slot + 1'b1;
            state <= S_READ_REQ;
          end else begin
            state <= S_FINISH;
          end
        end
        S_FINISH: state <= S_IDLE;
        default:  state <= S_IDLE;
      endcase
    end
  end

  noStartBusy: assert property (@(posedge clk) disable iff (reset) busy |-> !start)
    else $error("stack port %0d: start while busy", BASE);

  indexRange: assert property (@(posedge clk) disable iff (reset) index <= FULL)
    else $error("stack port %0d: index %0d above full", BASE, index);

  donePulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else $error("stack port %0d: done longer than one cycle", BASE);

endmodule

// ==== verilog/stackPair.sv ====
`timescale 1ns/1ps

// Data and return stacks sharing one RAM
module stackPair #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  // Data stack
  input  logic                   dStart,
  input  stackPkg::stackCtrl_t   dCtrl,
  input  logic [WIDTH-1:0]       dData,
  input  logic [DEPTH:0]         dOffset,
  input  logic [DEPTH:0]         dUnderflowLimit,
  input  logic [DEPTH:0]         dUpperLimit,
  input  logic [DEPTH:0]         dLowerLimit,
  output logic                   dBusy,
  output logic                   dDone,
  output logic [DEPTH:0]         dIndex,
  output logic [WIDTH-1:0]       dOut,
  output logic [WIDTH-1:0]       dOut1,
  output logic [WIDTH-1:0]       dOut2,
  output stackPkg::stackStatus_t dStatus,
  // Return stack
  input  logic                   rStart,
  input  stackPkg::stackCtrl_t   rCtrl,
  input  logic [WIDTH-1:0]       rData,
  input  logic [DEPTH:0]         rOffset,
  input  logic [DEPTH:0]         rUnderflowLimit,
  input  logic [DEPTH:0]         rUpperLimit,
  input  logic [DEPTH:0]         rLowerLimit,
  output logic                   rBusy,
  output logic                   rDone,
  output logic [DEPTH:0]         rIndex,
  output logic [WIDTH-1:0]       rOut,
  output logic [WIDTH-1:0]       rOut1,
  output logic [WIDTH-1:0]       rOut2,
  output stackPkg::stackStatus_t rStatus
);
  import stackPkg::*;

  logic [1:0]       req;
  logic [1:0]       we;
  logic [1:0]       gnt;
  logic [DEPTH-1:0] dAddr;
  logic [DEPTH-1:0] rAddr;
  logic [WIDTH-1:0] dWdata;
  logic [WIDTH-1:0] rWdata;
  logic             ramWe;
  logic [DEPTH:0]   ramAddr;
  logic [WIDTH-1:0] ramWdata;
  logic [WIDTH-1:0] ramRdata;  // Seen by both units

  stackUnit #(.WIDTH(WIDTH), .DEPTH(DEPTH), .BASE(PORT_DATA)) dataStack (
    .clk, .reset,
    .start(dStart), .ctrl(dCtrl), .data(dData), .offset(dOffset),
    .underflowLimit(dUnderflowLimit), .upperLimit(dUpperLimit), .lowerLimit(dLowerLimit),
    .busy(dBusy), .done(dDone), .index(dIndex),
    .out(dOut), .out1(dOut1), .out2(dOut2), .status(dStatus),
    .memReq(req[PORT_DATA]), .memWe(we[PORT_DATA]), .memAddr(dAddr), .memWdata(dWdata),
    .memGnt(gnt[PORT_DATA]), .memRdata(ramRdata)
  );

  stackUnit #(.WIDTH(WIDTH), .DEPTH(DEPTH), .BASE(PORT_RETURN)) returnStack (
    .clk, .reset,
    .start(rStart), .ctrl(rCtrl), .data(rData), .offset(rOffset),
    .underflowLimit(rUnderflowLimit), .upperLimit(rUpperLimit), .lowerLimit(rLowerLimit),
    .busy(rBusy), .done(rDone), .index(rIndex),
    .out(rOut), .out1(rOut1), .out2(rOut2), .status(rStatus),
    .memReq(req[PORT_RETURN]), .memWe(we[PORT_RETURN]), .memAddr(rAddr),
    .memWdata(rWdata), .memGnt(gnt[PORT_RETURN]), .memRdata(ramRdata)
  );

  memArbiter #(.WIDTH(WIDTH), .DEPTH(DEPTH)) arbiter (
    .clk, .reset, .req, .we,
    .addr0(dAddr), .addr1(rAddr), .wdata0(dWdata), .wdata1(rWdata),
    .gnt, .ramWe, .ramAddr, .ramWdata
  );

  stackRam #(.WIDTH(WIDTH), .DEPTH(DEPTH)) ram (
    .clk, .we(ramWe), .addr(ramAddr), .wdata(ramWdata), .rdata(ramRdata)
  );

endmodule

// ==== verif/stackPairTb.sv ====
`timescale 1ns/1ps

// Directed tests for the data and return stacks against a reference model
module stackPairTb;
  import stackPkg::*;

  localparam int WIDTH = 8;
  localparam int DEPTH = 4;
  localparam int FULL = 2 ** DEPTH;
  localparam int TIMEOUT_CYCLES = 6000;  // ~300 commands of up to 12 cycles, plus margin

  logic                  clk;
  logic                  reset;
  logic [1:0]            start;
  stackCtrl_t            ctrl [2];
  logic [WIDTH-1:0]      data [2];
  logic [DEPTH:0]        offset [2];
  logic [DEPTH:0]        underflowLimit [2];
  logic [DEPTH:0]        upperLimit [2];
  logic [DEPTH:0]        lowerLimit [2];
  wire  [1:0]            busy;
  wire  [1:0]            done;
  wire  [1:0][DEPTH:0]   index;
  wire  [1:0][WIDTH-1:0] out0;
  wire  [1:0][WIDTH-1:0] out1;
  wire  [1:0][WIDTH-1:0] out2;
  wire  [1:0][2:0]       status;

  // Reference model, one entry per stack
  logic [WIDTH-1:0] modelMem [2][FULL];
  int               modelIndex [2];
  logic [WIDTH-1:0] modelOut [2][3];
  stackStatus_t     modelStatus [2];

  integer seed;
  int     errors;
  int     checks;
  int     cycles;

  always #2 clk = ~clk;

  stackPair #(.WIDTH(WIDTH), .DEPTH(DEPTH)) dut_i (
    .clk, .reset,
    .dStart(start[0]), .dCtrl(ctrl[0]), .dData(data[0]), .dOffset(offset[0]),
    .dUnderflowLimit(underflowLimit[0]), .dUpperLimit(upperLimit[0]),
    .dLowerLimit(lowerLimit[0]), .dBusy(busy[0]), .dDone(done[0]), .dIndex(index[0]),
    .dOut(out0[0]), .dOut1(out1[0]), .dOut2(out2[0]), .dStatus(status[0]),
    .rStart(start[1]), .rCtrl(ctrl[1]), .rData(data[1]), .rOffset(offset[1]),
    .rUnderflowLimit(underflowLimit[1]), .rUpperLimit(upperLimit[1]),
    .rLowerLimit(lowerLimit[1]), .rBusy(busy[1]), .rDone(done[1]), .rIndex(index[1]),
    .rOut(out0[1]), .rOut1(out1[1]), .rOut2(out2[1]), .rStatus(status[1])
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  // Stack level after a command that passed its checks
  function automatic stackStatus_t statusFor(input int idx, input int limit);
    if (idx == FULL) return ST_FULL;
    if (idx == limit) return ST_EMPTY;
    if (idx < limit) return ST_UNDERFLOW;
    return ST_NONE;
  endfunction

  task automatic refreshTop(input int s);
    int k;
    int pos;
    for (k = 0; k < 3; k++) begin
      pos = modelIndex[s] - 1 - k;
      modelOut[s][k] = (pos >= 0) ? modelMem[s][pos] : '0;  // Zero below the bottom
    end
  endtask

  task automatic applyModel(input int s, input stackOp_t op, input logic drop,
                            input logic [WIDTH-1:0] d, input int off);
    int   idx;
    int   lim;
    int   win;
    int   newIdx;
    logic reload;
    logic rule;
    logic badWindow;
    idx = modelIndex[s];
    lim = underflowLimit[s];
    win = (int'(lowerLimit[s]) + off) % FULL;
    badWindow = (int'(upperLimit[s]) - int'(lowerLimit[s])) <= off;
    newIdx = idx;
    reload = 1'b0;
    rule = 1'b0;
    case (op)
      OP_NONE: rule = 1'b1;
      OP_PUSH: begin
        if (idx == FULL) begin
          modelStatus[s] = ST_OVERFLOW;
        end else begin
          modelMem[s][idx] = d;
          newIdx = idx + 1;
          reload = 1'b1;
          rule = 1'b1;
        end
      end
      OP_POP: begin
        if (idx - int'(d) <= lim) begin
          modelStatus[s] = ST_UNDERFLOW;
        end else begin
          newIdx = idx - int'(d) - 1;  // Count of zero still drops one
          reload = 1'b1;
          rule = 1'b1;
        end
      end
      OP_REPLACE: begin
        if (idx <= lim) begin
          modelStatus[s] = ST_UNDERFLOW;
        end else begin
          modelMem[s][idx - 1] = d;
          reload = 1'b1;
          rule = 1'b1;
        end
      end
      OP_INDEX_RESET: begin
        if (off > idx) begin
          modelStatus[s] = ST_BAD_OFFSET;
        end else begin
          newIdx = off;
          rule = 1'b1;
        end
      end
      OP_INDEX_PUSH: begin
        if (off > idx) begin
          modelStatus[s] = ST_BAD_OFFSET;
        end else if (off == FULL) begin
          modelStatus[s] = ST_OVERFLOW;
        end else begin
          modelMem[s][off] = d;
          newIdx = off + 1;
          reload = 1'b1;
          rule = 1'b1;
        end
      end
      OP_UNDERFLOW_GET: begin
        if (badWindow) begin
          modelStatus[s] = ST_BAD_OFFSET;
        end else begin
          modelOut[s][0] = modelMem[s][win];  // out only
          modelStatus[s] = ST_NONE;
        end
      end
      OP_UNDERFLOW_SET: begin
        if (badWindow) begin
          modelStatus[s] = ST_BAD_OFFSET;
        end else if (drop && (idx == lim || idx == 0)) begin
          modelStatus[s] = ST_UNDERFLOW;
        end else begin
          modelMem[s][win] = d;
          if (drop) newIdx = idx - 1;
          rule = 1'b1;
        end
      end
      default: rule = 1'b0;
    endcase
    modelIndex[s] = newIdx;
    if (reload) refreshTop(s);
    if (rule) modelStatus[s] = statusFor(newIdx, lim);
  endtask

  // Puts one command on a stack's inputs and steps the model
  task automatic setCommand(input int s, input stackOp_t op, input logic drop,
                            input logic [WIDTH-1:0] d, input int off);
    ctrl[s].op = op;
    ctrl[s].dropTos = drop;
    data[s] = d;
    offset[s] = off[DEPTH:0];
    applyModel(s, op, drop, d, off);
  endtask

  task automatic checkStack(input int s);
    string            name;
    logic [DEPTH:0]   expIdx;
    logic [WIDTH-1:0] got [3];
    int               k;
    name = (s == PORT_DATA) ? "data" : "return";
    expIdx = modelIndex[s];
    got[0] = out0[s];
    got[1] = out1[s];
    got[2] = out2[s];
    checks++;
    if (index[s] !== expIdx) begin
      $display("[FAIL] %0t: %s stack index %0d, expected %0d", $time, name, index[s], expIdx);
      errors++;
    end
    if (status[s] !== modelStatus[s]) begin
      $display("[FAIL] %0t: %s stack status %0d, expected %s", $time, name, status[s],
               modelStatus[s].name());
      errors++;
    end
    for (k = 0; k < 3; k++) begin
      if (got[k] !== modelOut[s][k]) begin
        $display("[FAIL] %0t: %s stack top entry %0d is %h, expected %h", $time, name, k,
                 got[k], modelOut[s][k]);
        errors++;
      end
    end
  endtask

  // Starts the loaded commands together and checks each stack at its done
  task automatic runCommands(input logic [1:0] mask);
    logic [1:0] pending;
    int         s;
    pending = mask;
    start = mask;
    @(negedge clk);
    start = 2'b00;
    while (pending != 2'b00) begin
      for (s = 0; s < 2; s++) begin
        if (!mask[s] && done[s]) begin
          $display("Stack %0d signalled done without a command at %0t", s, $time);
          errors++;
        end
        if (pending[s] && busy[s] !== 1'b1) begin
          $display("[FAIL] %0t: stack %0d not busy during its command", $time, s);
          errors++;
        end
        if (pending[s] && done[s]) begin
          checkStack(s);
          pending[s] = 1'b0;
        end
      end
      if (pending != 2'b00) @(negedge clk);
    end
    @(negedge clk);  // Unit drops back to idle the cycle after done
    for (s = 0; s < 2; s++) begin
      if (mask[s] && (busy[s] !== 1'b0 || done[s] !== 1'b0)) begin
        $display("[FAIL] %0t: stack %0d busy %b done %b after its command, expected 0 0",
                 $time, s, busy[s], done[s]);
        errors++;
      end
    end
  endtask

  task automatic pushAndPop();
    int i;
    for (i = 0; i < 5; i++) begin
      setCommand(PORT_DATA, OP_PUSH, 1'b0, $random(seed), 0);
      runCommands(2'b01);
    end
    setCommand(PORT_DATA, OP_POP, 1'b0, 8'd0, 0);
    runCommands(2'b01);
    setCommand(PORT_DATA, OP_POP, 1'b0, 8'd2, 0);
    runCommands(2'b01);
  endtask

  task automatic fillToOverflow();
    while (modelIndex[PORT_RETURN] < FULL) begin
      setCommand(PORT_RETURN, OP_PUSH, 1'b0, $random(seed), 0);
      runCommands(2'b10);
    end
    if (status[PORT_RETURN] !== ST_FULL) begin
      $display("[FAIL] %0t: return stack not full after %0d pushes", $time, FULL);
      errors++;
    end
    setCommand(PORT_RETURN, OP_PUSH, 1'b0, $random(seed), 0);  // One too many
    runCommands(2'b10);
  endtask

  task automatic limitChecks();
    int i;
    for (i = 0; i < 4; i++) begin
      setCommand(PORT_DATA, OP_PUSH, 1'b0, $random(seed), 0);
      runCommands(2'b01);
    end
    underflowLimit[PORT_DATA] = 3;
    setCommand(PORT_DATA, OP_NONE, 1'b0, 8'd0, 0);
    runCommands(2'b01);
    setCommand(PORT_DATA, OP_POP, 1'b0, 8'd1, 0);  // Lands on the limit
    runCommands(2'b01);
    setCommand(PORT_DATA, OP_POP, 1'b0, 8'd0, 0);
    runCommands(2'b01);
    setCommand(PORT_DATA, OP_REPLACE, 1'b0, $random(seed), 0);
    runCommands(2'b01);
    underflowLimit[PORT_DATA] = 2;
    setCommand(PORT_DATA, OP_REPLACE, 1'b0, $random(seed), 0);
    runCommands(2'b01);
    underflowLimit[PORT_DATA] = 0;
    setCommand(PORT_DATA, OP_NONE, 1'b0, 8'd0, 0);
    runCommands(2'b01);
  endtask

  task automatic indexOps();
    setCommand(PORT_DATA, OP_INDEX_RESET, 1'b0, 8'd0, 1);
    runCommands(2'b01);
    setCommand(PORT_DATA, OP_INDEX_RESET, 1'b0, 8'd0, 4);  // Above the index
    runCommands(2'b01);
    setCommand(PORT_DATA, OP_INDEX_PUSH, 1'b0, $random(seed), 1);
    runCommands(2'b01);
    setCommand(PORT_DATA, OP_INDEX_PUSH, 1'b0, $random(seed), 0);
    runCommands(2'b01);
    setCommand(PORT_RETURN, OP_INDEX_PUSH, 1'b0, $random(seed), FULL);  // Full stack
    runCommands(2'b10);
  endtask

  task automatic underflowWindow();
    int i;
    for (i = 0; i < 4; i++) begin
      setCommand(PORT_DATA, OP_PUSH, 1'b0, $random(seed), 0);
      runCommands(2'b01);
    end
    upperLimit[PORT_DATA] = 5;
    setCommand(PORT_DATA, OP_UNDERFLOW_GET, 1'b0, 8'd0, 2);
    runCommands(2'b01);
    setCommand(PORT_DATA, OP_UNDERFLOW_GET, 1'b0, 8'd0, 5);  // Outside the window
    runCommands(2'b01);
    setCommand(PORT_DATA, OP_UNDERFLOW_SET, 1'b0, $random(seed), 1);
    runCommands(2'b01);
    setCommand(PORT_DATA, OP_UNDERFLOW_GET, 1'b0, 8'd0, 1);
    runCommands(2'b01);
    setCommand(PORT_DATA, OP_UNDERFLOW_SET, 1'b1, $random(seed), 3);
    runCommands(2'b01);
    setCommand(PORT_DATA, OP_UNDERFLOW_GET, 1'b0, 8'd0, 3);
    runCommands(2'b01);
    underflowLimit[PORT_DATA] = 4;
    setCommand(PORT_DATA, OP_UNDERFLOW_SET, 1'b1, $random(seed), 0);  // Drop at the limit
    runCommands(2'b01);
    underflowLimit[PORT_DATA] = 0;
    upperLimit[PORT_DATA] = FULL;
    lowerLimit[PORT_RETURN] = 8;
    setCommand(PORT_RETURN, OP_UNDERFLOW_GET, 1'b0, 8'd0, 3);
    runCommands(2'b10);
    lowerLimit[PORT_RETURN] = 0;
  endtask

  // Random mix on both stacks, started in the same cycle
  task automatic bothStacks();
    int               r;
    int               s;
    int               pick;
    int               off;
    logic [WIDTH-1:0] d;
    stackOp_t         op;
    for (r = 0; r < 120; r++) begin
      for (s = 0; s < 2; s++) begin
        pick = $unsigned($random(seed)) % 5;
        off = 0;
        if (modelIndex[s] > 0) off = $unsigned($random(seed)) % modelIndex[s];
        d = $random(seed);
        case (pick)
          0, 1: op = OP_PUSH;
          2: begin
            op = OP_POP;
            d = d % 3;  // Small counts
          end
          3: op = OP_REPLACE;
          default: op = OP_UNDERFLOW_GET;
        endcase
        setCommand(s, op, 1'b0, d, off);
      end
      runCommands(2'b11);
    end
  endtask

  initial begin
    int s;
    int k;
    clk = 1'b0;
    reset = 1'b1;
    start = 2'b00;
    seed = 32'hee170bc8;
    errors = 0;
    checks = 0;
    cycles = 0;
    for (s = 0; s < 2; s++) begin
      ctrl[s] = '0;
      data[s] = '0;
      offset[s] = '0;
      underflowLimit[s] = '0;
      upperLimit[s] = FULL;
      lowerLimit[s] = '0;
      for (k = 0; k < FULL; k++) begin
        modelMem[s][k] = '0;
      end
      for (k = 0; k < 3; k++) begin
        modelOut[s][k] = '0;
      end
      modelIndex[s] = 0;
      modelStatus[s] = ST_EMPTY;
    end
    repeat (8) @(negedge clk);
    reset = 1'b0;
    checkStack(PORT_DATA);  // Reset values
    checkStack(PORT_RETURN);
    pushAndPop();
    fillToOverflow();
    limitChecks();
    indexOps();
    underflowWindow();
    bothStacks();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/stackPkg.sv
verilog/stackRam.sv
verilog/memArbiter.sv
verilog/stackUnit.sv
verilog/stackPair.sv
verif/stackPairTb.sv

// ==== Bender.yml ====
package:
  name: stack_pair

sources:
  # Synthesizable design, package first
  - files:
      - verilog/stackPkg.sv
      - verilog/stackRam.sv
      - verilog/memArbiter.sv
      - verilog/stackUnit.sv
      - verilog/stackPair.sv

  # Simulation only
  - target: test
    files:
      - verif/stackPairTb.sv
